//--- bch_pkg.sv
`default_nettype none

package bch_pkg;

	// **************************************************
	// field and code parameters
	// **************************************************

	parameter int M = 4;                          // field degree.
	parameter int T = 3;                          // correctable errors.
	parameter int N_BITS = (1 << M) - 1;          // codeword length.
	parameter int SYN_COUNT = 2 * T - 1;          // S_1 .. S_2T-1.

	// x^4 + x + 1, bit i is the coefficient of x^i.
	parameter logic [M:0] PRIM_POLY = 'b1_0011;

	// **************************************************
	// types
	// **************************************************

	typedef logic [M-1:0] gf_elem_t;
	typedef logic [SYN_COUNT*M-1:0] syn_vec_t;    // slot k holds S_(k+1).
	typedef logic [M-1:0] lfsr_count_t;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		DONE
	} syn_state_t;

	// **************************************************
	// field arithmetic
	// **************************************************

	// one step of multiplication by alpha in polynomial basis.
	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
		gf_elem_t r;
		r = {a[M-2:0], 1'b0};
		if (a[M-1])
			r = r ^ PRIM_POLY[M-1:0];            // reduce x^M.
		return r;
	endfunction

	// a * alpha^j. only ever called with constant j.
	function automatic gf_elem_t gf_mul_alpha_pow(input gf_elem_t a, input int unsigned j);
		gf_elem_t r;
		r = a;
		for (int unsigned i = 0; i < j; i++)
			r = gf_mul_alpha(r);
		return r;
	endfunction

	// counter state after a number of steps from seed 1.
	// the counter is a multiply-by-alpha lfsr, so this is alpha^steps.
	function automatic lfsr_count_t lfsr_count_at(input int unsigned steps);
		return lfsr_count_t'(gf_mul_alpha_pow(gf_elem_t'(1), steps));
	endfunction

endpackage

`default_nettype wire

//--- lfsr_counter.sv
`default_nettype none

// maximal-length galois lfsr used as a position counter.
// it walks all 2^M-1 nonzero states, no adder needed.
module lfsr_counter (
	input wire clk,
	input wire arst_n,
	input wire logic restart,
	input wire logic step,
	output bch_pkg::lfsr_count_t count
);

	import bch_pkg::*;

	localparam lfsr_count_t SEED = lfsr_count_t'(1);

	lfsr_count_t count_next;

	// taps come from PRIM_POLY via the package helper.
	assign count_next = lfsr_count_t'(gf_mul_alpha(gf_elem_t'(count)));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= SEED;
		end else if (restart) begin
			count <= SEED;                        // restart wins over step.
		end else if (step) begin
			count <= count_next;
		end
	end

endmodule

`default_nettype wire

//--- bch_bit_fifo.sv
`default_nettype none

// small bit fifo behind a credit interface.
// every pop returns one credit to the sender in the same cycle.
module bch_bit_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire arst_n,
	input wire logic in_valid,
	input wire logic in_data,
	input wire logic in_first,
	output logic bit_ce,
	output logic bit_data,
	output logic bit_first,
	output logic credit
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// **************************************************
	// storage and pointers
	// **************************************************

	logic [1:0] mem [FIFO_DEPTH];                 // {first, data}.
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] level;
	logic pop;

	// wrap at FIFO_DEPTH so non power of two depths work.
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		logic [PTR_W-1:0] r;
		if (p == PTR_W'(FIFO_DEPTH - 1))
			r = '0;
		else
			r = p + 1'b1;
		return r;
	endfunction

	// the syndrome unit never stalls, so pop whenever data is held.
	assign pop = (level != '0);

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= {in_first, in_data};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);

			// occupancy; credits keep this from exceeding the depth.
			case ({in_valid, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// **************************************************
	// outputs
	// **************************************************

	assign bit_ce = pop;
	assign bit_first = mem[rd_ptr][1];
	assign bit_data = mem[rd_ptr][0];
	assign credit = pop;                          // one credit per popped bit.

endmodule

`default_nettype wire

//--- bch_syndrome.sv
`default_nettype none

// serial syndrome unit, S_j = r(alpha^j) for j = 1 .. 2T-1.
// bits arrive highest degree first, one Horner step per bit.
module bch_syndrome (
	input wire clk,
	input wire arst_n,
	input wire logic bit_ce,
	input wire logic bit_first,
	input wire logic bit_data,
	output bch_pkg::syn_vec_t syndromes,
	output logic done,
	output logic err_detect
);

	import bch_pkg::*;

	// counter value when the (n-1)-th bit has been taken.
	localparam lfsr_count_t LAST_POS = lfsr_count_at(N_BITS - 2);

	syn_state_t state;
	lfsr_count_t count;
	syn_vec_t syn_q;
	wire syn_vec_t syn_next;

	wire consume_first = bit_ce && bit_first;
	wire consume_busy = bit_ce && (state == BUSY);
	wire last_bit = consume_busy && !bit_first && (count == LAST_POS);

	lfsr_counter u_counter (
		.clk(clk),
		.arst_n(arst_n),
		.restart(consume_first),
		.step(consume_busy),
		.count(count)
	);

	// **************************************************
	// Horner step per syndrome
	// **************************************************

	for (genvar j = 0; j < SYN_COUNT; j++) begin : g_syn
		gf_elem_t prod;

		// constant multiply by alpha^(j+1) as an xor of basis columns.
		always_comb begin
			prod = '0;
			for (int b = 0; b < M; b++) begin
				if (syn_q[j*M + b])
					prod = prod ^ gf_mul_alpha_pow(gf_elem_t'(1) << b, j + 1);
			end
		end

		assign syn_next[j*M +: M] = prod ^ gf_elem_t'(bit_data);
	end

	always_ff @(posedge clk) begin
		if (consume_first) begin
			for (int j = 0; j < SYN_COUNT; j++)
				syn_q[j*M +: M] <= gf_elem_t'(bit_data);   // S_j = r_(n-1).
		end else if (consume_busy) begin
			syn_q <= syn_next;
		end
	end

	assign syndromes = syn_q;

	// **************************************************
	// control
	// **************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			done <= 1'b0;
			err_detect <= 1'b0;
		end else begin
			done <= last_bit;                     // one cycle pulse.
			if (last_bit)
				err_detect <= |syn_next;          // any syndrome nonzero.

			case (state)
				IDLE: if (consume_first) state <= BUSY;   // other bits dropped.
				BUSY: if (last_bit) state <= DONE;
				DONE: if (consume_first) state <= BUSY;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- bch_syndrome_shuffle.sv
`default_nettype none

// holds the finished syndromes for the key equation stage.
// each shuffle moves slot k+1 into slot k, slot 0 wraps to the top.
module bch_syndrome_shuffle (
	input wire clk,
	input wire arst_n,
	input wire logic done,
	input wire bch_pkg::syn_vec_t syndromes,
	input wire logic restart,
	input wire logic shuffle,
	output bch_pkg::syn_vec_t syn_window,
	output logic syn_valid
);

	import bch_pkg::*;

	syn_vec_t rotated;

	assign rotated = {syn_window[M-1:0], syn_window[SYN_COUNT*M-1:M]};

	always_ff @(posedge clk) begin
		if (done)
			syn_window <= syndromes;              // slot k = S_(k+1).
		else if (shuffle && syn_valid)
			syn_window <= rotated;
	end

	// a finished codeword wins over a new first bit in the same cycle,
	// the held window still belongs to the finished one.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			syn_valid <= 1'b0;
		else if (done)
			syn_valid <= 1'b1;
		else if (restart)
			syn_valid <= 1'b0;                    // new codeword started.
	end

endmodule

`default_nettype wire

//--- bch_syndrome_top.sv
`default_nettype none

// front end of the BCH decoder: credit fifo, syndrome unit, shuffle register.
module bch_syndrome_top #(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire arst_n,

	// credited serial input.
	input wire in_valid,
	input wire in_data,
	input wire in_first,
	output logic credit,

	// towards the key equation stage.
	input wire shuffle,
	output bch_pkg::syn_vec_t syn_window,
	output logic syn_valid,
	output logic err_detect
);

	import bch_pkg::*;

	wire bit_ce;
	wire bit_data;
	wire bit_first;
	wire done;
	wire syn_vec_t syndromes;
	wire restart = bit_ce & bit_first;            // first bit consumed.

	bch_bit_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_first(in_first),
		.bit_ce(bit_ce),
		.bit_data(bit_data),
		.bit_first(bit_first),
		.credit(credit)
	);

	bch_syndrome u_syndrome (
		.clk(clk),
		.arst_n(arst_n),
		.bit_ce(bit_ce),
		.bit_first(bit_first),
		.bit_data(bit_data),
		.syndromes(syndromes),
		.done(done),
		.err_detect(err_detect)
	);

	bch_syndrome_shuffle u_shuffle (
		.clk(clk),
		.arst_n(arst_n),
		.done(done),
		.syndromes(syndromes),
		.restart(restart),
		.shuffle(shuffle),
		.syn_window(syn_window),
		.syn_valid(syn_valid)
	);

endmodule

`default_nettype wire

//--- bch_syndrome_asserts.sv
`default_nettype none

// checks on the credit loop and the syndrome flags of the top level.
module bch_syndrome_asserts #(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire arst_n,
	input wire in_valid,
	input wire credit,
	input wire done,
	input wire syn_valid
);

	int outstanding;                              // bits sent, credit not yet back.
	logic seen_done;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			outstanding <= 0;
			seen_done <= 1'b0;
		end else begin
			outstanding <= outstanding + int'(in_valid) - int'(credit);
			if (done)
				seen_done <= 1'b1;                // first codeword finished.
		end
	end

	credit_low_in_reset: assert property (@(posedge clk) !arst_n |-> !credit)
		else $error("credit pulsed while in reset");

	credits_within_depth: assert property (@(posedge clk) disable iff (!arst_n)
		outstanding <= FIFO_DEPTH)
		else $error("more than FIFO_DEPTH credits outstanding");

	no_valid_before_done: assert property (@(posedge clk) disable iff (!arst_n)
		!seen_done |-> !syn_valid)
		else $error("syn_valid high before any codeword completed");

endmodule

bind bch_syndrome_top bch_syndrome_asserts #(
	.FIFO_DEPTH(FIFO_DEPTH)
) u_asserts (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.credit(credit),
	.done(done),
	.syn_valid(syn_valid)
);

`default_nettype wire

//--- tb_bch_syndrome.sv
`default_nettype none

module tb_bch_syndrome;

	import bch_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int SEND_LIMIT = 2000;             // cycles per codeword.
	localparam int WAIT_LIMIT = 200;

	typedef logic [N_BITS-1:0] word_t;           // bit i is the coefficient of x^i.

	logic clk;
	logic arst_n;
	logic in_valid;
	logic in_data;
	logic in_first;
	logic shuffle;
	wire credit;
	wire syn_vec_t syn_window;
	wire syn_valid;
	wire err_detect;

	integer seed = 57496;
	int errors = 0;
	int failed_tests = 0;
	int sent_total = 0;
	int returned_total = 0;
	logic syn_valid_q = 1'b0;
	syn_vec_t rise_windows [$];                   // window seen at each syn_valid rise.
	gf_elem_t alpha_exp [N_BITS];

	bch_syndrome_top #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) uut (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_first(in_first),
		.credit(credit),
		.shuffle(shuffle),
		.syn_window(syn_window),
		.syn_valid(syn_valid),
		.err_detect(err_detect)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// count credit returns and syn_valid rises before the edge updates them.
	always @(posedge clk) begin
		if (credit)
			returned_total <= returned_total + 1;
		if (syn_valid && !syn_valid_q)
			rise_windows.push_back(syn_window);
		syn_valid_q <= syn_valid;
	end

	// **************************************************
	// reference model
	// **************************************************

	function automatic void build_exp_table();
		gf_elem_t a;
		a = gf_elem_t'(1);
		for (int i = 0; i < N_BITS; i++) begin
			alpha_exp[i] = a;
			a = gf_elem_t'({a, 1'b0} ^ (a[M-1] ? PRIM_POLY : '0));
		end
	endfunction

	// S_j = r(alpha^j) as a sum of alpha^(j*i) over the set bits.
	function automatic gf_elem_t ref_syndrome(input word_t word, input int j);
		gf_elem_t s;
		s = '0;
		for (int i = 0; i < N_BITS; i++) begin
			if (word[i])
				s = s ^ alpha_exp[(j * i) % N_BITS];
		end
		return s;
	endfunction

	function automatic syn_vec_t ref_window(input word_t word, input int rot);
		syn_vec_t w;
		for (int k = 0; k < SYN_COUNT; k++)
			w[k*M +: M] = ref_syndrome(word, ((k + rot) % SYN_COUNT) + 1);
		return w;
	endfunction

	// **************************************************
	// drivers and checks
	// **************************************************

	// sends n bits highest degree first and never beyond the held credits.
	task automatic send_codeword(input word_t word, input bit gaps);
		int idx;
		int held;
		int cycles;
		idx = N_BITS - 1;
		cycles = 0;
		while (idx >= 0 && cycles < SEND_LIMIT) begin
			@(posedge clk);
			cycles++;
			held = FIFO_DEPTH - sent_total + returned_total + int'(credit);
			if (held > 0 && !(gaps && (($random(seed) & 3) == 0))) begin
				in_valid <= 1'b1;
				in_data <= word[idx];
				in_first <= (idx == N_BITS - 1);
				sent_total++;
				idx--;
			end else begin
				in_valid <= 1'b0;             // idle cycle.
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_first <= 1'b0;
		if (idx >= 0) begin
			$display("sender ran out of time with %0d bits left, credits never came back", idx + 1);
			errors++;
		end
	endtask

	task automatic wait_syn_valid(input string tag, output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
			ok = syn_valid;
		end
		if (!ok) begin
			$display("%s: syn_valid never rose after the codeword was sent", tag);
			errors++;
		end
	endtask

	task automatic check_window(input syn_vec_t exp_w, input string tag);
		for (int k = 0; k < SYN_COUNT; k++) begin
			assert (syn_window[k*M +: M] == exp_w[k*M +: M]) else begin
				$display("ERROR %s syn_window[%0d]: got %h, expected %h",
					tag, k, syn_window[k*M +: M], exp_w[k*M +: M]);
				errors++;
			end
		end
	endtask

	task automatic check_err_detect(input logic expected, input string tag);
		assert (err_detect == expected) else begin
			$display("ERROR %s err_detect: got %h, expected %h", tag, err_detect, expected);
			errors++;
		end
	endtask

	task automatic run_codeword(input word_t word, input bit gaps, input string tag);
		bit ok;
		send_codeword(word, gaps);
		wait_syn_valid(tag, ok);
		if (ok) begin
			check_window(ref_window(word, 0), tag);
			check_err_detect(ref_window(word, 0) != '0, tag);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			failed_tests++;
		end
	endtask

	// **************************************************
	// tests
	// **************************************************

	task automatic test_all_zero();
		int e0;
		e0 = errors;
		run_codeword('0, 1'b0, "all_zero");
		report_test("all_zero", e0);
	endtask

	task automatic test_single_error();
		int e0;
		int pos [4];
		bit ok;
		syn_vec_t exp_w;
		e0 = errors;
		pos = '{0, 4, 9, 14};
		foreach (pos[p]) begin
			send_codeword(word_t'(1) << pos[p], 1'b0);
			wait_syn_valid("single_error", ok);
			if (ok) begin
				for (int k = 0; k < SYN_COUNT; k++)
					exp_w[k*M +: M] = alpha_exp[((k + 1) * pos[p]) % N_BITS];
				check_window(exp_w, "single_error");
				check_err_detect(1'b1, "single_error");
			end
		end
		report_test("single_error", e0);
	endtask

	task automatic test_random_gaps();
		int e0;
		int sent0;
		int ret0;
		e0 = errors;
		sent0 = sent_total;
		ret0 = returned_total;
		for (int w = 0; w < 6; w++)
			run_codeword(word_t'($random(seed)), 1'b1, "random_gaps");
		repeat (2) @(posedge clk);
		assert (returned_total - ret0 == sent_total - sent0) else begin
			$display("ERROR random_gaps credit count: got %h, expected %h",
				returned_total - ret0, sent_total - sent0);
			errors++;
		end
		report_test("random_gaps", e0);
	endtask

	task automatic test_shuffle();
		int e0;
		word_t word;
		e0 = errors;
		word = word_t'($random(seed));
		run_codeword(word, 1'b0, "shuffle");
		for (int s = 1; s <= SYN_COUNT + 1; s++) begin
			@(posedge clk);
			shuffle <= 1'b1;
			@(posedge clk);
			shuffle <= 1'b0;
			@(posedge clk);                   // rotated window is out now.
			check_window(ref_window(word, s), "shuffle");
		end
		report_test("shuffle", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		int rises0;
		bit ok;
		word_t word_a;
		word_t word_b;
		e0 = errors;
		word_a = word_t'($random(seed));
		word_b = word_t'($random(seed));
		rises0 = rise_windows.size();
		send_codeword(word_a, 1'b0);          // no wait for syn_valid in between.
		send_codeword(word_b, 1'b0);
		wait_syn_valid("back_to_back", ok);
		if (ok) begin
			check_window(ref_window(word_b, 0), "back_to_back");
			check_err_detect(ref_window(word_b, 0) != '0, "back_to_back");
		end
		@(posedge clk);
		// a second rise only happens if syn_valid dropped when word_b began.
		if (rise_windows.size() != rises0 + 2) begin
			$display("back_to_back: syn_valid did not drop when the second codeword began");
			errors++;
		end else begin
			assert (rise_windows[rises0] == ref_window(word_a, 0)) else begin
				$display("ERROR back_to_back syn_window: got %h, expected %h",
					rise_windows[rises0], ref_window(word_a, 0));
				errors++;
			end
		end
		report_test("back_to_back", e0);
	endtask

	initial begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_data = 1'b0;
		in_first = 1'b0;
		shuffle = 1'b0;
		build_exp_table();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		test_all_zero();
		test_single_error();
		test_random_gaps();
		test_shuffle();
		test_back_to_back();

		$display("tests: 5, tests with errors: %0d, errors: %0d", failed_tests, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
bch_pkg.sv
lfsr_counter.sv
bch_bit_fifo.sv
bch_syndrome.sv
bch_syndrome_shuffle.sv
bch_syndrome_top.sv
bch_syndrome_asserts.sv
tb_bch_syndrome.sv

//--- Makefile
# Verilator simulation of the BCH syndrome front end.

TOP := tb_bch_syndrome

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
